//--- list.f
+incdir+source
source/cache_pkg.sv
source/cache_stream_fifo.sv
source/cache_directory.sv
source/cache_lookup.sv
source/cache_snoop.sv
source/cache_tag_engine.sv
testbench/cache_tag_engine_properties.sv
testbench/cache_tag_engine_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the cache tag engine testbench with Verilator and run it.
# The exit status of the simulation is the result of the run.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f list.f \
  --top-module cache_tag_engine_tb \
  --Mdir obj_dir \
  -o cache_tag_engine_sim

./obj_dir/cache_tag_engine_sim

//--- source/cache_directory.sv
// ----------------------------------------------------------
// Dual-port line directory, one state and tag per index, read
// combinationally on both ports and written at the clock edge
// ----------------------------------------------------------

`default_nettype none

module cache_directory (
  input  logic                     clk,
  input  logic                     rst,
  input  cache_pkg::dir_port_req_t port0_req,
  output cache_pkg::dir_port_rsp_t port0_rsp,
  input  cache_pkg::dir_port_req_t port1_req,
  output cache_pkg::dir_port_rsp_t port1_rsp
);

  localparam int LINES = 1 << $bits(cache_pkg::index_t);

  // Everything but the valid bit lives in RAM-style storage
  typedef struct packed {
    logic            d;
    logic            u;
    cache_pkg::tag_t tag;
  } ram_entry_t;

  logic [LINES-1:0] valid_q;
  ram_entry_t       ram_q [LINES];
  ram_entry_t       rd0_entry;
  ram_entry_t       rd1_entry;
  ram_entry_t       wr0_entry;
  ram_entry_t       wr1_entry;

  // Port reads
  always_comb begin
    rd0_entry = ram_q[port0_req.index];
    rd1_entry = ram_q[port1_req.index];

    port0_rsp.current_state.v = valid_q[port0_req.index];
    port0_rsp.current_state.d = rd0_entry.d;
    port0_rsp.current_state.u = rd0_entry.u;
    port0_rsp.current_tag     = rd0_entry.tag;

    port1_rsp.current_state.v = valid_q[port1_req.index];
    port1_rsp.current_state.d = rd1_entry.d;
    port1_rsp.current_state.u = rd1_entry.u;
    port1_rsp.current_tag     = rd1_entry.tag;
  end

  always_comb begin
    wr0_entry.d   = port0_req.next_state.d;
    wr0_entry.u   = port0_req.next_state.u;
    wr0_entry.tag = port0_req.next_tag;

    wr1_entry.d   = port1_req.next_state.d;
    wr1_entry.u   = port1_req.next_state.u;
    wr1_entry.tag = port1_req.next_tag;
  end

  // Valid bits come up cleared
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else begin
      if (port0_req.write) begin
        valid_q[port0_req.index] <= port0_req.next_state.v;
      end
      if (port1_req.write) begin
        valid_q[port1_req.index] <= port1_req.next_state.v;
      end
    end
  end

  // Ports never write the same index in one cycle
  always_ff @(posedge clk) begin
    if (port0_req.write) begin
      ram_q[port0_req.index] <= wr0_entry;
    end
    if (port1_req.write) begin
      ram_q[port1_req.index] <= wr1_entry;
    end
  end

endmodule

`default_nettype wire

//--- source/cache_lookup.sv
// ----------------------------------------------------------
// Lookup engine: takes one request per handshake, answers with
// hit/miss and victim info and updates the line on port 0
// ----------------------------------------------------------

`default_nettype none

module cache_lookup (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     req_valid,
  output logic                     req_ready,
  input  cache_pkg::cache_req_t    req,
  output logic                     rsp_valid,
  input  logic                     rsp_ready,
  output cache_pkg::cache_rsp_t    rsp,
  output cache_pkg::dir_port_req_t dir_req,
  input  cache_pkg::dir_port_rsp_t dir_rsp
);

  logic                   active_q;
  logic                   fire;
  logic                   is_write;
  logic                   tag_match;
  logic                   hit;
  cache_pkg::line_state_t cur_state;
  cache_pkg::line_state_t next_state;

  // Low for the first cycle out of reset, while the queues settle
  always_ff @(posedge clk) begin
    if (rst) begin
      active_q <= 1'b0;
    end else begin
      active_q <= 1'b1;
    end
  end

  // Request and response streams move together
  assign rsp_valid = req_valid && active_q;
  assign req_ready = rsp_ready && active_q;
  assign fire      = req_valid && rsp_ready && active_q;

  assign cur_state = dir_rsp.current_state;
  assign is_write  = (req.op == cache_pkg::op_write);
  assign tag_match = (dir_rsp.current_tag == req.tag);
  assign hit       = cur_state.v && tag_match;

  // New line state
  always_comb begin
    next_state.v = 1'b1;
    if (hit) begin
      next_state.u = 1'b1;
      next_state.d = cur_state.d || is_write;
    end else begin
      // Fresh allocation, not yet reused
      next_state.u = 1'b0;
      next_state.d = is_write;
    end
  end

  always_comb begin
    rsp.hit        = hit;
    rsp.prev_state = cur_state;
    rsp.prev_tag   = dir_rsp.current_tag;
    rsp.index      = req.index;
    rsp.evict      = !hit && cur_state.v && cur_state.d;
  end

  // Port 0 reads the request's line and writes it back on handshake
  always_comb begin
    dir_req.index      = req.index;
    dir_req.write      = fire;
    dir_req.next_state = next_state;
    dir_req.next_tag   = req.tag;
  end

endmodule

`default_nettype wire

//--- source/cache_params.svh
// ----------------------------------------------------------
// Size macros for the cache tag engine, included by the package
// and by the top level that sizes the stream queues
// ----------------------------------------------------------

`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// Index bits, 16 lines
`define CACHE_INDEX_WIDTH 4

// Tag bits kept per line
`define CACHE_TAG_WIDTH 8

// Entries in each request and response queue
`define CACHE_QUEUE_DEPTH 4

`endif

//--- source/cache_pkg.sv
// ----------------------------------------------------------
// Shared types of the cache tag engine: line state, request and
// response streams, directory ports and snoop traffic
// ----------------------------------------------------------

`default_nettype none

`include "cache_params.svh"

package cache_pkg;

  typedef logic [`CACHE_INDEX_WIDTH-1:0] index_t;
  typedef logic [`CACHE_TAG_WIDTH-1:0] tag_t;

  typedef struct packed {
    logic v;
    logic d;
    logic u;
  } line_state_t;

  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } cache_op_t;

  typedef struct packed {
    cache_op_t op;
    tag_t      tag;
    index_t    index;
  } cache_req_t;

  typedef struct packed {
    logic        hit;
    line_state_t prev_state;
    tag_t        prev_tag;
    index_t      index;
    logic        evict;   // victim is valid and dirty
  } cache_rsp_t;

  // One directory port, read is combinational on index
  typedef struct packed {
    index_t      index;
    logic        write;
    line_state_t next_state;
    tag_t        next_tag;
  } dir_port_req_t;

  typedef struct packed {
    line_state_t current_state;
    tag_t        current_tag;
  } dir_port_rsp_t;

  typedef struct packed {
    tag_t   tag;
    index_t index;
  } snoop_req_t;

  typedef struct packed {
    logic hit;
    logic dirty;
  } snoop_rsp_t;

endpackage

`default_nettype wire

//--- source/cache_snoop.sv
// ----------------------------------------------------------
// Snoop engine on directory port 1: invalidates a matching line
// and reports hit and dirty one cycle after acceptance
// ----------------------------------------------------------

`default_nettype none

module cache_snoop (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     snoop_valid,
  output logic                     snoop_ready,
  input  cache_pkg::snoop_req_t    snoop,
  output logic                     snoop_rsp_valid,
  output cache_pkg::snoop_rsp_t    snoop_rsp,
  input  cache_pkg::dir_port_req_t lookup_dir_req,
  output cache_pkg::dir_port_req_t dir_req,
  input  cache_pkg::dir_port_rsp_t dir_rsp
);

  logic                  conflict;
  logic                  accept;
  logic                  hit;
  cache_pkg::snoop_rsp_t result;

  // Lookup is updating this very line, wait a cycle
  assign conflict    = lookup_dir_req.write && (lookup_dir_req.index == snoop.index);
  assign snoop_ready = !conflict;
  assign accept      = snoop_valid && snoop_ready;

  assign hit = dir_rsp.current_state.v && (dir_rsp.current_tag == snoop.tag);

  assign result.hit   = hit;
  assign result.dirty = hit && dir_rsp.current_state.d;

  // Invalidate on hit, keep tag and used bit
  always_comb begin
    dir_req.index        = snoop.index;
    dir_req.write        = accept && hit;
    dir_req.next_state.v = 1'b0;
    dir_req.next_state.d = 1'b0;
    dir_req.next_state.u = dir_rsp.current_state.u;
    dir_req.next_tag     = dir_rsp.current_tag;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      snoop_rsp_valid <= 1'b0;
    end else begin
      snoop_rsp_valid <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      snoop_rsp <= result;
    end
  end

endmodule

`default_nettype wire

//--- source/cache_stream_fifo.sv
// ----------------------------------------------------------
// Valid/ready stream FIFO for any packed payload type
// ----------------------------------------------------------

`default_nettype none

module cache_stream_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 2
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_COUNT = CNT_W'(DEPTH);

  payload_t mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic push;
  logic pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == LAST_SLOT) begin
      return '0;
    end
    return ptr + PTR_W'(1);
  endfunction

  // Head entry is presented straight from storage
  assign out_valid = (count_q != '0);
  assign out_data  = mem_q[rd_ptr_q];

  // A full queue still takes a push when the head leaves this cycle
  assign in_ready = (count_q != FULL_COUNT) || out_ready;

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + CNT_W'(1);
        2'b01:   count_q <= count_q - CNT_W'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_data;
    end
  end

endmodule

`default_nettype wire

//--- source/cache_tag_engine.sv
// ----------------------------------------------------------
// Cache tag engine top: request queue, lookup, response queue,
// snoop invalidation and the shared dual-port directory
// ----------------------------------------------------------

`default_nettype none

`include "cache_params.svh"

module cache_tag_engine (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  req_valid,
  output logic                  req_ready,
  input  cache_pkg::cache_req_t req,
  output logic                  rsp_valid,
  input  logic                  rsp_ready,
  output cache_pkg::cache_rsp_t rsp,
  input  logic                  snoop_valid,
  output logic                  snoop_ready,
  input  cache_pkg::snoop_req_t snoop,
  output logic                  snoop_rsp_valid,
  output cache_pkg::snoop_rsp_t snoop_rsp
);

  // Request queue to lookup
  logic                  req_q_valid;
  logic                  req_q_ready;
  cache_pkg::cache_req_t req_q;

  // Lookup to response queue
  logic                  lookup_rsp_valid;
  logic                  lookup_rsp_ready;
  cache_pkg::cache_rsp_t lookup_rsp;

  cache_pkg::dir_port_req_t dir0_req;
  cache_pkg::dir_port_rsp_t dir0_rsp;
  cache_pkg::dir_port_req_t dir1_req;
  cache_pkg::dir_port_rsp_t dir1_rsp;

  cache_stream_fifo #(
    .payload_t (cache_pkg::cache_req_t),
    .DEPTH     (`CACHE_QUEUE_DEPTH)
  ) u_req_fifo (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (req_valid),
    .in_ready  (req_ready),
    .in_data   (req),
    .out_valid (req_q_valid),
    .out_ready (req_q_ready),
    .out_data  (req_q)
  );

  cache_lookup u_lookup (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_q_valid),
    .req_ready (req_q_ready),
    .req       (req_q),
    .rsp_valid (lookup_rsp_valid),
    .rsp_ready (lookup_rsp_ready),
    .rsp       (lookup_rsp),
    .dir_req   (dir0_req),
    .dir_rsp   (dir0_rsp)
  );

  cache_stream_fifo #(
    .payload_t (cache_pkg::cache_rsp_t),
    .DEPTH     (`CACHE_QUEUE_DEPTH)
  ) u_rsp_fifo (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (lookup_rsp_valid),
    .in_ready  (lookup_rsp_ready),
    .in_data   (lookup_rsp),
    .out_valid (rsp_valid),
    .out_ready (rsp_ready),
    .out_data  (rsp)
  );

  // Snoop sees the lookup's port-0 write for its conflict stall
  cache_snoop u_snoop (
    .clk             (clk),
    .rst             (rst),
    .snoop_valid     (snoop_valid),
    .snoop_ready     (snoop_ready),
    .snoop           (snoop),
    .snoop_rsp_valid (snoop_rsp_valid),
    .snoop_rsp       (snoop_rsp),
    .lookup_dir_req  (dir0_req),
    .dir_req         (dir1_req),
    .dir_rsp         (dir1_rsp)
  );

  cache_directory u_directory (
    .clk       (clk),
    .rst       (rst),
    .port0_req (dir0_req),
    .port0_rsp (dir0_rsp),
    .port1_req (dir1_req),
    .port1_rsp (dir1_rsp)
  );

endmodule

`default_nettype wire

//--- testbench/cache_tag_engine_properties.sv
// ------------------------------------------------------------
// Handshake assertions, bound into the cache tag engine top
// ------------------------------------------------------------

`default_nettype none

module cache_tag_engine_properties (
  input logic                  clk,
  input logic                  rst,
  input logic                  req_valid,
  input logic                  req_ready,
  input cache_pkg::cache_req_t req,
  input logic                  rsp_valid,
  input logic                  rsp_ready,
  input cache_pkg::cache_rsp_t rsp,
  input logic                  snoop_valid,
  input logic                  snoop_ready,
  input cache_pkg::snoop_req_t snoop,
  input logic                  snoop_rsp_valid
);
  timeunit 1ns;
  timeprecision 100ps;

  // Stalled streams hold valid and payload
  req_hold: assert property (@(posedge clk) disable iff (rst)
    req_valid && !req_ready |=> req_valid && $stable(req))
    else $error("request changed while stalled");

  rsp_hold: assert property (@(posedge clk) disable iff (rst)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
    else $error("response changed while stalled");

  snoop_hold: assert property (@(posedge clk) disable iff (rst)
    snoop_valid && !snoop_ready |=> snoop_valid && $stable(snoop))
    else $error("snoop changed while stalled");

  quiet_after_reset: assert property (@(posedge clk)
    rst |=> !rsp_valid && !snoop_rsp_valid)
    else $error("valid output high right after reset");

  // Snoop result exactly one cycle after acceptance
  snoop_result_due: assert property (@(posedge clk) disable iff (rst)
    snoop_valid && snoop_ready |=> snoop_rsp_valid)
    else $error("snoop result missing");

  snoop_result_cause: assert property (@(posedge clk) disable iff (rst)
    snoop_rsp_valid |-> $past(snoop_valid && snoop_ready))
    else $error("snoop result without acceptance");

endmodule

bind cache_tag_engine cache_tag_engine_properties u_properties (
  .clk             (clk),
  .rst             (rst),
  .req_valid       (req_valid),
  .req_ready       (req_ready),
  .req             (req),
  .rsp_valid       (rsp_valid),
  .rsp_ready       (rsp_ready),
  .rsp             (rsp),
  .snoop_valid     (snoop_valid),
  .snoop_ready     (snoop_ready),
  .snoop           (snoop),
  .snoop_rsp_valid (snoop_rsp_valid)
);

`default_nettype wire

//--- testbench/cache_tag_engine_tb.sv
// ------------------------------------------------------------
// Testbench for the cache tag engine: random requests and snoops
// checked against a directory model kept in the testbench
// ------------------------------------------------------------

`default_nettype none

`include "cache_params.svh"

module cache_tag_engine_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int LINES        = 1 << `CACHE_INDEX_WIDTH;
  localparam int RANDOM_OPS   = 200;
  localparam int SNOOP_ROUNDS = 20;
  localparam int TOTAL_OPS    = LINES * 3 + 8 + RANDOM_OPS + SNOOP_ROUNDS * 2 + 8;

  logic                  clk;
  logic                  rst;
  logic                  req_valid;
  logic                  req_ready;
  cache_pkg::cache_req_t req;
  logic                  rsp_valid;
  logic                  rsp_ready;
  cache_pkg::cache_rsp_t rsp;
  logic                  snoop_valid;
  logic                  snoop_ready;
  cache_pkg::snoop_req_t snoop;
  logic                  snoop_rsp_valid;
  cache_pkg::snoop_rsp_t snoop_rsp;

  // Reference directory
  cache_pkg::line_state_t model_state [LINES];
  cache_pkg::tag_t        model_tag   [LINES];
  logic                   model_known [LINES];

  cache_pkg::cache_rsp_t exp_rsp_q  [$];
  cache_pkg::cache_rsp_t exp_mask_q [$];
  string                 exp_name_q [$];
  cache_pkg::snoop_rsp_t snoop_exp;
  string                 snoop_name;
  string                 req_name;
  int                    seed;
  logic                  rsp_random;
  logic                  req_taken;
  logic                  snoop_taken;
  logic                  snoop_wait;

  cache_tag_engine u_cache_tag_engine (
    .clk             (clk),
    .rst             (rst),
    .req_valid       (req_valid),
    .req_ready       (req_ready),
    .req             (req),
    .rsp_valid       (rsp_valid),
    .rsp_ready       (rsp_ready),
    .rsp             (rsp),
    .snoop_valid     (snoop_valid),
    .snoop_ready     (snoop_ready),
    .snoop           (snoop),
    .snoop_rsp_valid (snoop_rsp_valid),
    .snoop_rsp       (snoop_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    repeat (TOTAL_OPS * 40) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d cycles", TOTAL_OPS * 40);
    $display("Simulation FAILED");
    $fatal(1, "watchdog expired");
  end

  function automatic logic random_bit();
    int r;
    r = $random(seed);
    return r[0];
  endfunction

  // Small tag range so that lines get reused
  function automatic cache_pkg::tag_t random_tag();
    int r;
    r = $random(seed);
    return cache_pkg::tag_t'(r[1:0]);
  endfunction

  function automatic cache_pkg::index_t random_index();
    int r;
    r = $random(seed);
    return cache_pkg::index_t'(r);
  endfunction

  // Fields of a never written line are masked out
  task automatic check_rsp(input string name, input cache_pkg::cache_rsp_t exp,
                           input cache_pkg::cache_rsp_t mask, input cache_pkg::cache_rsp_t act);
    if (((exp ^ act) & mask) !== '0) begin
      $display("ERR %s: expected %h actual %h (mask %h)", name, exp, act, mask);
      $display("Simulation FAILED");
      $fatal(1, "response mismatch");
    end
  endtask

  task automatic check_snoop(input string name, input cache_pkg::snoop_rsp_t exp,
                             input cache_pkg::snoop_rsp_t act);
    if (exp !== act) begin
      $display("ERR %s: expected %h actual %h", name, exp, act);
      $display("Simulation FAILED");
      $fatal(1, "snoop result mismatch");
    end
  endtask

  // Expected response from the model, then the line update
  task automatic model_request(input string name, input cache_pkg::cache_req_t r);
    cache_pkg::line_state_t s;
    cache_pkg::cache_rsp_t  e;
    cache_pkg::cache_rsp_t  m;
    logic                   is_hit;
    s      = model_state[r.index];
    is_hit = s.v && (model_tag[r.index] == r.tag);
    e.hit        = is_hit;
    e.prev_state = s;
    e.prev_tag   = model_tag[r.index];
    e.index      = r.index;
    e.evict      = !is_hit && s.v && s.d;
    m = '1;
    if (!model_known[r.index]) begin
      m.prev_state.d = 1'b0;
      m.prev_state.u = 1'b0;
      m.prev_tag     = '0;
    end
    exp_rsp_q.push_back(e);
    exp_mask_q.push_back(m);
    exp_name_q.push_back(name);
    if (is_hit) begin
      s.u = 1'b1;
      s.d = s.d || (r.op == cache_pkg::op_write);
    end else begin
      s.v = 1'b1;
      s.u = 1'b0;
      s.d = (r.op == cache_pkg::op_write);
    end
    model_state[r.index] = s;
    model_tag[r.index]   = r.tag;
    model_known[r.index] = 1'b1;
  endtask

  task automatic model_snoop(input cache_pkg::snoop_req_t sn);
    logic is_hit;
    is_hit          = model_state[sn.index].v && (model_tag[sn.index] == sn.tag);
    snoop_exp.hit   = is_hit;
    snoop_exp.dirty = is_hit && model_state[sn.index].d;
    if (is_hit) begin
      model_state[sn.index].v = 1'b0;
      model_state[sn.index].d = 1'b0;
    end
  endtask

  // Samples handshakes on the falling edge and drives 5 ns after the rising edge
  task automatic run_cycle();
    @(negedge clk);
    if (rsp_valid && rsp_ready) begin
      if (exp_rsp_q.size() == 0) begin
        $display("A response came out with no request outstanding");
        $display("Simulation FAILED");
        $fatal(1, "unexpected response");
      end else begin
        check_rsp(exp_name_q.pop_front(), exp_rsp_q.pop_front(), exp_mask_q.pop_front(), rsp);
      end
    end
    if (snoop_wait) begin
      snoop_wait = 1'b0;
      if (!snoop_rsp_valid) begin
        $display("Snoop result missing one cycle after acceptance");
        $display("Simulation FAILED");
        $fatal(1, "snoop result late");
      end else begin
        check_snoop(snoop_name, snoop_exp, snoop_rsp);
      end
    end else if (snoop_rsp_valid) begin
      $display("Snoop result came out with no snoop accepted");
      $display("Simulation FAILED");
      $fatal(1, "unexpected snoop result");
    end
    if (req_valid && req_ready) begin
      model_request(req_name, req);
      req_taken = 1'b1;
    end
    if (snoop_valid && snoop_ready) begin
      model_snoop(snoop);
      snoop_wait  = 1'b1;
      snoop_taken = 1'b1;
    end
    @(posedge clk);
    #5;
    rsp_ready = rsp_random ? random_bit() : 1'b1;
  endtask

  task automatic send_req(input string name, input cache_pkg::cache_op_t op,
                          input cache_pkg::tag_t tag, input cache_pkg::index_t index);
    req_valid = 1'b1;
    req.op    = op;
    req.tag   = tag;
    req.index = index;
    req_name  = name;
    req_taken = 1'b0;
    while (!req_taken) begin
      run_cycle();
    end
    req_valid = 1'b0;
  endtask

  task automatic drain();
    while (exp_rsp_q.size() != 0) begin
      run_cycle();
    end
  endtask

  // Snoops go out only with the request path idle, so no conflict can stall them
  task automatic send_snoop(input string name, input cache_pkg::tag_t tag,
                            input cache_pkg::index_t index);
    drain();
    snoop_valid = 1'b1;
    snoop.tag   = tag;
    snoop.index = index;
    snoop_name  = name;
    snoop_taken = 1'b0;
    run_cycle();
    snoop_valid = 1'b0;
    if (!snoop_taken) begin
      $display("Snoop %s was stalled while the request path was idle", name);
      $display("Simulation FAILED");
      $fatal(1, "snoop stalled");
    end else begin
      run_cycle();
    end
  endtask

  initial begin
    cache_pkg::tag_t   t;
    cache_pkg::index_t idx;
    seed        = 32'h2d0c_a54c;
    rst         = 1'b1;
    req_valid   = 1'b0;
    req         = '0;
    rsp_ready   = 1'b1;
    snoop_valid = 1'b0;
    snoop       = '0;
    rsp_random  = 1'b0;
    req_taken   = 1'b0;
    snoop_taken = 1'b0;
    snoop_wait  = 1'b0;
    model_state = '{default: '0};
    model_tag   = '{default: '0};
    model_known = '{default: 1'b0};
    repeat (3) @(posedge clk);
    #5;
    rst = 1'b0;

    // Cold lines miss, then hit, then hit with u already set
    for (int i = 0; i < LINES; i++) begin
      t   = random_tag();
      idx = cache_pkg::index_t'(i);
      send_req($sformatf("cold_miss[%0d]", i), cache_pkg::op_read, t, idx);
      send_req($sformatf("first_hit[%0d]", i), cache_pkg::op_read, t, idx);
      send_req($sformatf("used_hit[%0d]", i), cache_pkg::op_read, t, idx);
    end

    // Dirty victim on a conflicting tag
    for (int k = 0; k < 4; k++) begin
      idx = cache_pkg::index_t'(k * 4 + 1);
      send_req("evict_write", cache_pkg::op_write, cache_pkg::tag_t'(8'hA0 + k), idx);
      send_req("evict_read", cache_pkg::op_read, cache_pkg::tag_t'(8'h50 + k), idx);
    end

    rsp_random = 1'b1;
    for (int n = 0; n < RANDOM_OPS; n++) begin
      if (random_bit() && random_bit()) begin
        run_cycle();
      end
      send_req("random_mix", cache_pkg::cache_op_t'(random_bit()), random_tag(), random_index());
    end
    rsp_random = 1'b0;
    drain();

    // Invalidation of a dirty line, then an absent tag
    send_req("dirty_fill", cache_pkg::op_write, 8'hC3, 4'd9);
    send_snoop("snoop_dirty", 8'hC3, 4'd9);
    send_req("after_snoop", cache_pkg::op_read, 8'hC3, 4'd9);
    send_req("absent_fill", cache_pkg::op_write, 8'h3C, 4'd12);
    send_req("absent_hit", cache_pkg::op_read, 8'h3C, 4'd12);
    send_snoop("snoop_absent", 8'h77, 4'd12);
    send_req("after_absent", cache_pkg::op_read, 8'h3C, 4'd12);

    for (int n = 0; n < SNOOP_ROUNDS; n++) begin
      send_snoop("snoop_random", random_tag(), random_index());
      send_req("snoop_mix", cache_pkg::cache_op_t'(random_bit()), random_tag(), random_index());
    end
    drain();
    run_cycle();
    @(negedge clk);

    // Idle engine has empty queues and no result pending
    if (rsp_valid || snoop_rsp_valid || !req_ready || !snoop_ready) begin
      $display("Engine not idle at the end of the run");
      $display("Simulation FAILED");
      $fatal(1, "engine busy at end");
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire
